// ==== bench/gmii_tx_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module gmii_tx_properties (
	input wire       fifo_clk,
	input wire       sys_rst,
	input wire       empty,
	input wire       rd_en,
	input wire       tx_en,
	input wire [7:0] txd
);
	import gmii_tx_pkg::*;

	// Show-ahead FIFO is only popped with a word present
	pop_needs_data: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		rd_en |-> !empty)
		else $error("rd_en high while the FIFO is empty");

	idle_txd_zero: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		!tx_en |-> txd == 8'h00)
		else $error("txd not zero while tx_en is low");

	// Gap after every frame
	gap_after_frame: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$fell(tx_en) |-> !tx_en [*IFG_CYCLES])
		else $error("inter-frame gap shorter than IFG_CYCLES");

endmodule

bind gmii_tx_top gmii_tx_properties i_gmii_tx_properties (
	.fifo_clk (fifo_clk),
	.sys_rst  (sys_rst),
	.empty    (empty),
	.rd_en    (rd_en),
	.tx_en    (tx_en),
	.txd      (txd)
);

`default_nettype wire

// ==== bench/tb_gmii_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gmii_tx;
	import gmii_tx_pkg::*;

	typedef struct packed {
		logic        id;
		logic        sw;
		logic [11:0] line_y;
		logic [11:0] pix_x;
	} stim_row_t;

	localparam int NUM_ROWS       = 5;
	localparam int WORDS          = 600;
	localparam int FRAME_CYCLES   = 1259;
	localparam int TIMEOUT_CYCLES = 16 + NUM_ROWS * (FRAME_CYCLES + IFG_CYCLES + 64);

	logic        fifo_clk;
	logic        sys_rst;
	logic        id;
	logic        sw;
	pixel_word_u dout;
	logic        empty;
	wire         rd_en;
	wire         tx_en;
	wire  [7:0]  txd;

	stim_row_t   stim_tbl [NUM_ROWS];
	stim_row_t   cur_row;
	pixel_word_u loaded [WORDS];
	pixel_word_u fifo_q [$];
	pixel_word_u pop_q [$];
	logic [7:0]  exp_q [$];
	logic [7:0]  cap_q [$];
	logic [31:0] exp_fcs;
	logic [31:0] rnd;
	int          byte_errs = 0;
	int          fcs_errs = 0;
	int          word_errs = 0;
	int          other_errs = 0;
	int          frames_done = 0;
	int          run_len = 0;
	int          idle_len = 0;
	int          cycles = 0;

	gmii_tx_top i_gmii_tx_top (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.id       (id),
		.sw       (sw),
		.dout     (dout),
		.empty    (empty),
		.rd_en    (rd_en),
		.tx_en    (tx_en),
		.txd      (txd)
	);

	initial begin
		fifo_clk = 1'b0;
		forever #2 fifo_clk = ~fifo_clk;
	end

	// ----------------------------------------------------------------------
	// Compare tasks
	// ----------------------------------------------------------------------
	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int off);
		if (got !== exp) begin
			$display("Mismatch txd at offset %0d: got 0x%h expected 0x%h", off, got, exp);
			byte_errs++;
		end
	endtask

	task automatic check_fcs(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch fcs: got 0x%h expected 0x%h", got, exp);
			fcs_errs++;
		end
	endtask

	task automatic check_word(input pixel_word_u got, input pixel_word_u exp, input int idx);
		if (got !== exp) begin
			$display("Mismatch dout word %0d: got 0x%h expected 0x%h", idx, got, exp);
			word_errs++;
		end
	endtask

	// ----------------------------------------------------------------------
	// Reference frame
	// ----------------------------------------------------------------------
	task automatic put_bytes(input logic [47:0] v, input int n);
		for (int i = n - 1; i >= 0; i--) begin
			exp_q.push_back(v[i*8 +: 8]);
		end
	endtask

	// One's-complement sum over the ten IPv4 header words
	function automatic logic [15:0] ip_checksum(input logic stn);
		logic [31:0] sum;
		sum = 32'h4500 + 32'd1233 + 32'h0000 + 32'h4000 + 32'h4011
			+ 32'hc0a8 + (32'h0001 + stn) + 32'hc0a8 + (32'h0002 - stn);
		while (sum[31:16] != 0) begin
			sum = sum[15:0] + sum[31:16];
		end
		return ~sum[15:0];
	endfunction

	function automatic logic [31:0] frame_crc(input int first, input int last);
		logic [31:0] c;
		logic [7:0]  b;
		c = 32'hffff_ffff;
		for (int n = first; n <= last; n++) begin
			b = exp_q[n];
			for (int i = 0; i < 8; i++) begin
				c = (c >> 1) ^ ((c[0] ^ b[i]) ? 32'hedb8_8320 : 32'h0);
			end
		end
		return ~c;
	endfunction

	task automatic build_frame(input stim_row_t r);
		exp_q.delete();
		for (int i = 0; i < 7; i++) begin
			exp_q.push_back(8'h55);
		end
		exp_q.push_back(8'hd5);
		put_bytes(48'h0023_4567_8902 - r.id, 6);
		put_bytes(48'h0023_4567_8901 + r.id, 6);
		put_bytes(16'h0800, 2);
		// Version/TOS, total length 1233, ident, flags, TTL, protocol
		put_bytes(48'h4500_04d1_0000, 6);
		put_bytes(32'h4000_4011, 4);
		put_bytes(ip_checksum(r.id), 2);
		put_bytes(32'hc0a8_0001 + r.id, 4);
		put_bytes(32'hc0a8_0002 - r.id, 4);
		// Ports, UDP length 1213, zero checksum
		put_bytes(48'h3038_3039_04bd, 6);
		put_bytes(16'h0000, 2);
		exp_q.push_back(8'h00);
		put_bytes({4'h0, r.line_y, 4'h0, r.pix_x}, 4);
		for (int k = 0; k < WORDS; k++) begin
			exp_q.push_back(r.sw ? loaded[k].rgb.green : loaded[k].yuv.luma);
			exp_q.push_back(r.sw ? loaded[k].rgb.red : loaded[k].yuv.chroma);
		end
		exp_fcs = frame_crc(8, exp_q.size() - 1);
	endtask

	// Show-ahead FIFO model, records the word the DUT saw at each pop
	always @(posedge fifo_clk) begin
		if (rd_en) begin
			if (fifo_q.size() == 0) begin
				$display("FIFO was read while the FIFO model was empty");
				other_errs++;
			end else begin
				pop_q.push_back(dout);
				fifo_q.delete(0);
				if (fifo_q.size() == 0) begin
					empty <= 1'b1;
					dout  <= '0;
				end else begin
					dout <= fifo_q[0];
				end
			end
		end
	end

	// GMII monitor, frame length and gap
	always @(negedge fifo_clk) begin
		if (!sys_rst && tx_en) begin
			if (run_len == 0 && frames_done > 0 && idle_len < IFG_CYCLES) begin
				$display("Inter-frame gap of %0d cycles is too short", idle_len);
				other_errs++;
			end
			cap_q.push_back(txd);
			run_len++;
			idle_len = 0;
		end else if (!sys_rst) begin
			if (run_len != 0) begin
				if (run_len != FRAME_CYCLES) begin
					$display("Mismatch tx_en length: got 0x%h expected 0x%h",
						run_len, FRAME_CYCLES);
					other_errs++;
				end
				frames_done++;
				run_len = 0;
			end
			idle_len++;
		end
	end

	always @(posedge fifo_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles waiting for the frames", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		void'($urandom(32'h3bd67429));
		stim_tbl[0] = {1'b0, 1'b0, 12'h001, 12'h280};
		stim_tbl[1] = {1'b1, 1'b1, 12'h2d0, 12'h500};
		stim_tbl[2] = {1'b0, 1'b1, 12'hfff, 12'h000};
		stim_tbl[3] = {1'b1, 1'b0, 12'h123, 12'habc};
		stim_tbl[4] = {1'b1, 1'b1, 12'h800, 12'hfff};
		sys_rst = 1'b1;
		id      = 1'b0;
		sw      = 1'b0;
		dout    = '0;
		empty   = 1'b1;
		repeat (16) @(posedge fifo_clk);
		sys_rst <= 1'b0;
		// Empty FIFO must keep the transmitter quiet
		repeat (20) begin
			@(negedge fifo_clk);
			if (tx_en !== 1'b0 || rd_en !== 1'b0 || txd !== 8'h00) begin
				$display("Transmitter active after reset with an empty FIFO");
				other_errs++;
			end
		end
		for (int r = 0; r < NUM_ROWS; r++) begin
			cur_row = stim_tbl[r];
			@(posedge fifo_clk);
			fifo_q.delete();
			pop_q.delete();
			cap_q.delete();
			for (int k = 0; k < WORDS; k++) begin
				rnd = $urandom();
				loaded[k] = {cur_row.line_y, cur_row.pix_x, rnd[23:0]};
				fifo_q.push_back(loaded[k]);
			end
			build_frame(cur_row);
			id    <= cur_row.id;
			sw    <= cur_row.sw;
			dout  <= fifo_q[0];
			empty <= 1'b0;
			while (frames_done != r + 1) begin
				@(posedge fifo_clk);
			end
			if (cap_q.size() != FRAME_CYCLES) begin
				$display("Captured %0d bytes in frame %0d instead of 1259", cap_q.size(), r);
				other_errs++;
			end else begin
				for (int n = 0; n < FRAME_CYCLES - 4; n++) begin
					check_byte(cap_q[n], exp_q[n], n);
				end
				check_fcs({cap_q[1258], cap_q[1257], cap_q[1256], cap_q[1255]}, exp_fcs);
			end
			if (pop_q.size() != WORDS || fifo_q.size() != 0 || !empty) begin
				$display("Frame %0d popped %0d words and left the FIFO not empty", r,
					pop_q.size());
				other_errs++;
			end
			for (int k = 0; k < pop_q.size() && k < WORDS; k++) begin
				check_word(pop_q[k], loaded[k], k);
			end
		end
		$display("Errors: byte %0d, fcs %0d, word %0d, other %0d",
			byte_errs, fcs_errs, word_errs, other_errs);
		if (byte_errs + fcs_errs + word_errs + other_errs == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/crc32_fcs_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32_fcs_stage (
	input  wire                        fifo_clk,
	input  wire                        sys_rst,
	input  wire gmii_tx_pkg::tx_slot_t slot,
	input  wire [7:0]                  hdr_byte,
	input  wire [7:0]                  res_byte,
	input  wire [7:0]                  pix_byte,
	output logic                       tx_en,
	output logic [7:0]                 txd
);
	import gmii_tx_pkg::*;

	logic [7:0]  byte_sel;
	logic [31:0] crc;
	logic [31:0] fcs;
	logic        crc_en;

	// Bitwise reflected CRC-32, one byte per call, LSB first
	function automatic logic [31:0] crc32_update(input logic [31:0] crc_in,
			input logic [7:0] data);
		logic [31:0] c;
		c = crc_in ^ {24'd0, data};
		for (int i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ CRC32_POLY_REFL) : (c >> 1);
		end
		return c;
	endfunction

	assign fcs    = ~crc;
	assign crc_en = (slot.phase == PH_HDR) || (slot.phase == PH_PID)
		|| (slot.phase == PH_RES) || (slot.phase == PH_PIX);

	always_comb begin
		case (slot.phase)
			PH_PRE:  byte_sel = PREAMBLE_BYTE;
			PH_SFD:  byte_sel = SFD_BYTE;
			PH_HDR:  byte_sel = hdr_byte;
			PH_PID:  byte_sel = PKT_ID_VIDEO;
			PH_RES:  byte_sel = res_byte;
			PH_PIX:  byte_sel = pix_byte;
			// FCS goes out least significant byte first
			PH_FCS:  byte_sel = fcs[{slot.index[1:0], 3'b000} +: 8];
			default: byte_sel = 8'h00;
		endcase
	end

	// Preset during SFD, then accumulate header through last pixel
	always_ff @(posedge fifo_clk) begin
		if (slot.phase == PH_SFD) begin
			crc <= CRC32_INIT;
		end else if (crc_en) begin
			crc <= crc32_update(crc, byte_sel);
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			tx_en <= 1'b0;
			txd   <= 8'h00;
		end else begin
			tx_en <= (slot.phase != PH_IDLE);
			txd   <= byte_sel;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/gmii_tx_pkg.sv ====
`default_nettype none

package gmii_tx_pkg;

	// ----------------------------------------------------------------------
	// Frame phases, encoded in transmit order
	// ----------------------------------------------------------------------
	localparam logic [2:0] PH_IDLE = 3'd0;
	localparam logic [2:0] PH_PRE  = 3'd1;
	localparam logic [2:0] PH_SFD  = 3'd2;
	localparam logic [2:0] PH_HDR  = 3'd3;
	localparam logic [2:0] PH_PID  = 3'd4;
	localparam logic [2:0] PH_RES  = 3'd5;
	localparam logic [2:0] PH_PIX  = 3'd6;
	localparam logic [2:0] PH_FCS  = 3'd7;

	localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0] SFD_BYTE      = 8'hD5;
	localparam logic [7:0] PKT_ID_VIDEO  = 8'h00;

	// Byte counts per phase
	localparam logic [10:0] PREAMBLE_LEN = 11'd7;
	localparam logic [10:0] HDR_LEN      = 11'd42;
	localparam logic [10:0] RES_LEN      = 11'd4;
	localparam logic [10:0] PIXEL_BYTES  = 11'd1200;
	localparam logic [10:0] FCS_LEN      = 11'd4;
	localparam logic [10:0] IFG_CYCLES   = 11'd12;

	// ----------------------------------------------------------------------
	// Ethernet, IPv4 and UDP header fields
	// ----------------------------------------------------------------------
	localparam logic [47:0] DST_MAC      = 48'h00_23_45_67_89_02;
	localparam logic [47:0] SRC_MAC      = 48'h00_23_45_67_89_01;
	localparam logic [15:0] ETH_TYPE     = 16'h0800;
	localparam logic [15:0] IP_VER_TOS   = 16'h4500;
	localparam logic [15:0] IP_IDENT     = 16'h0000;
	localparam logic [15:0] IP_FLAGS     = 16'h4000;
	localparam logic [7:0]  IP_TTL       = 8'h40;
	localparam logic [7:0]  IP_PROTO     = 8'h11;
	localparam logic [31:0] IP_SRC       = {8'd192, 8'd168, 8'd0, 8'd1};
	localparam logic [31:0] IP_DST       = {8'd192, 8'd168, 8'd0, 8'd2};
	localparam logic [15:0] UDP_SRC_PORT = 16'h3038;
	localparam logic [15:0] UDP_DST_PORT = 16'h3039;
	// 20 IP + 8 UDP + 1 packet id + 4 resolution + 1200 pixel bytes
	localparam logic [15:0] IP_TOTAL_LEN = 16'd1233;
	localparam logic [15:0] UDP_LEN      = 16'd1213;

	// Reflected form of polynomial 0x04C11DB7
	localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB8_8320;
	localparam logic [31:0] CRC32_INIT      = 32'hFFFF_FFFF;

	// One FIFO word, read as YUV or as RGB depending on sw
	typedef union packed {
		struct packed {
			logic [11:0] line_y;
			logic [11:0] pix_x;
			logic [7:0]  luma;
			logic [7:0]  chroma;
			logic [7:0]  spare;
		} yuv;
		struct packed {
			logic [11:0] line_y;
			logic [11:0] pix_x;
			logic [7:0]  red;
			logic [7:0]  green;
			logic [7:0]  blue;
		} rgb;
	} pixel_word_u;

	typedef struct packed {
		logic [2:0]  phase;
		logic [10:0] index;
	} tx_slot_t;

endpackage

`default_nettype wire

// ==== hdl/gmii_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gmii_tx_top (
	input  wire                           fifo_clk,
	input  wire                           sys_rst,
	input  wire                           id,
	input  wire                           sw,
	input  wire gmii_tx_pkg::pixel_word_u dout,
	input  wire                           empty,
	output wire                           rd_en,
	output wire                           tx_en,
	output wire [7:0]                     txd
);
	import gmii_tx_pkg::*;

	wire tx_slot_t slot;
	wire [7:0]     hdr_byte;
	wire [7:0]     res_byte;
	wire [7:0]     pix_byte;

	tx_frame_ctrl i_tx_frame_ctrl (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.empty    (empty),
		.slot     (slot),
		.rd_en    (rd_en)
	);

	udp_header_gen i_udp_header_gen (
		.slot     (slot),
		.id       (id),
		.hdr_byte (hdr_byte)
	);

	video_payload_gen i_video_payload_gen (
		.slot     (slot),
		.dout     (dout),
		.sw       (sw),
		.res_byte (res_byte),
		.pix_byte (pix_byte)
	);

	// Output register stage, one cycle behind the slot
	crc32_fcs_stage i_crc32_fcs_stage (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.slot     (slot),
		.hdr_byte (hdr_byte),
		.res_byte (res_byte),
		.pix_byte (pix_byte),
		.tx_en    (tx_en),
		.txd      (txd)
	);

endmodule

`default_nettype wire

// ==== hdl/tx_frame_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_frame_ctrl (
	input  wire                   fifo_clk,
	input  wire                   sys_rst,
	input  wire                   empty,
	output gmii_tx_pkg::tx_slot_t slot,
	output logic                  rd_en
);
	import gmii_tx_pkg::*;

	logic [10:0] gap_cnt;
	logic        gap_done;
	logic [10:0] cur_len;
	logic        last_byte;

	// Number of cycles spent in each phase
	function automatic logic [10:0] phase_len(input logic [2:0] ph);
		logic [10:0] len;
		case (ph)
			PH_PRE:  len = PREAMBLE_LEN;
			PH_HDR:  len = HDR_LEN;
			PH_RES:  len = RES_LEN;
			PH_PIX:  len = PIXEL_BYTES;
			PH_FCS:  len = FCS_LEN;
			// SFD and packet id are single bytes
			default: len = 11'd1;
		endcase
		return len;
	endfunction

	assign cur_len   = phase_len(slot.phase);
	assign last_byte = (slot.index == cur_len - 11'd1);
	assign gap_done  = (gap_cnt == 11'd0);

	// ----------------------------------------------------------------------
	// Phase sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			slot.phase <= PH_IDLE;
			slot.index <= 11'd0;
			gap_cnt    <= 11'd0;
		end else if (slot.phase == PH_IDLE) begin
			slot.index <= 11'd0;
			if (!gap_done) begin
				gap_cnt <= gap_cnt - 11'd1;
			end else if (!empty) begin
				// Whole line is expected in the FIFO by now
				slot.phase <= PH_PRE;
			end
		end else if (last_byte) begin
			slot.index <= 11'd0;
			if (slot.phase == PH_FCS) begin
				slot.phase <= PH_IDLE;
				// Idle cycle at gap_cnt == 0 completes the gap
				gap_cnt    <= IFG_CYCLES - 11'd1;
			end else begin
				slot.phase <= slot.phase + 3'd1;
			end
		end else begin
			slot.index <= slot.index + 11'd1;
		end
	end

	// ----------------------------------------------------------------------
	// FIFO pop
	// ----------------------------------------------------------------------
	// Each word carries two pixel bytes. The head word stays in place
	// through the resolution bytes and the first pixel pair, and is popped
	// on the odd byte so the next word shows at the following even index
	assign rd_en = (slot.phase == PH_PIX) && slot.index[0];

endmodule

`default_nettype wire

// ==== hdl/udp_header_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module udp_header_gen (
	input  wire gmii_tx_pkg::tx_slot_t slot,
	input  wire                        id,
	output logic [7:0]                 hdr_byte
);
	import gmii_tx_pkg::*;

	logic [7:0]              id_byte;
	logic [47:0]             dst_mac_adj;
	logic [47:0]             src_mac_adj;
	logic [31:0]             ip_src_adj;
	logic [31:0]             ip_dst_adj;
	logic [19:0]             csum_sum;
	logic [16:0]             csum_fold;
	logic [15:0]             ip_csum;
	logic [HDR_LEN-1:0][7:0] hdr_vec;
	logic [10:0]             hdr_sel;

	// Station id nudges the low address bytes
	assign id_byte     = {7'd0, id};
	assign dst_mac_adj = {DST_MAC[47:8], DST_MAC[7:0] - id_byte};
	assign src_mac_adj = {SRC_MAC[47:8], SRC_MAC[7:0] + id_byte};
	assign ip_src_adj  = {IP_SRC[31:8], IP_SRC[7:0] + id_byte};
	assign ip_dst_adj  = {IP_DST[31:8], IP_DST[7:0] - id_byte};

	// ----------------------------------------------------------------------
	// IPv4 header checksum
	// ----------------------------------------------------------------------
	// Checksum word itself contributes zero
	assign csum_sum = {4'd0, IP_VER_TOS} + {4'd0, IP_TOTAL_LEN}
		+ {4'd0, IP_IDENT} + {4'd0, IP_FLAGS} + {4'd0, IP_TTL, IP_PROTO}
		+ {4'd0, ip_src_adj[31:16]} + {4'd0, ip_src_adj[15:0]}
		+ {4'd0, ip_dst_adj[31:16]} + {4'd0, ip_dst_adj[15:0]};

	// Two end-around carry folds are enough for nine terms
	assign csum_fold = {1'b0, csum_sum[15:0]} + {13'd0, csum_sum[19:16]};
	assign ip_csum   = ~(csum_fold[15:0] + {15'd0, csum_fold[16]});

	// Header laid out first byte at the top
	assign hdr_vec = {
		dst_mac_adj, src_mac_adj, ETH_TYPE,
		IP_VER_TOS, IP_TOTAL_LEN, IP_IDENT, IP_FLAGS,
		IP_TTL, IP_PROTO, ip_csum, ip_src_adj, ip_dst_adj,
		UDP_SRC_PORT, UDP_DST_PORT, UDP_LEN,
		16'h0000
	};

	assign hdr_sel  = HDR_LEN - 11'd1 - slot.index;
	assign hdr_byte = (slot.phase == PH_HDR) ? hdr_vec[hdr_sel] : 8'h00;

endmodule

`default_nettype wire

// ==== hdl/video_payload_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_payload_gen (
	input  wire gmii_tx_pkg::tx_slot_t    slot,
	input  wire gmii_tx_pkg::pixel_word_u dout,
	input  wire                           sw,
	output logic [7:0]                    res_byte,
	output logic [7:0]                    pix_byte
);
	import gmii_tx_pkg::*;

	// Resolution bytes, line then column, 16 bits each, high byte first
	always_comb begin
		case (slot.index[1:0])
			2'd0:    res_byte = {4'd0, dout.yuv.line_y[11:8]};
			2'd1:    res_byte = dout.yuv.line_y[7:0];
			2'd2:    res_byte = {4'd0, dout.yuv.pix_x[11:8]};
			default: res_byte = dout.yuv.pix_x[7:0];
		endcase
	end

	// Even bytes carry luma or green, odd bytes chroma or red
	always_comb begin
		if (!slot.index[0]) begin
			pix_byte = sw ? dout.rgb.green : dout.yuv.luma;
		end else begin
			pix_byte = sw ? dout.rgb.red : dout.yuv.chroma;
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/gmii_tx_pkg.sv
hdl/tx_frame_ctrl.sv
hdl/udp_header_gen.sv
hdl/video_payload_gen.sv
hdl/crc32_fcs_stage.sv
hdl/gmii_tx_top.sv
bench/gmii_tx_properties.sv
bench/tb_gmii_tx.sv
